// ==== logic/csr_pkg.sv ====
package csr_pkg;

   localparam int xlen_gp = 64;

   typedef logic [11:0] csr_addr_t;

   typedef enum logic [3:0] {
      e_rw,
      e_rs,
      e_rc,
      e_rwi,
      e_rsi,
      e_rci,
      e_ecall,
      e_ebreak,
      e_mret,
      e_none
   } csr_op_e;

   typedef enum logic [1:0] {
      e_priv_u = 2'b00,
      e_priv_m = 2'b11
   } priv_e;

   localparam csr_addr_t addr_cycle_gc         = 12'hc00;
   localparam csr_addr_t addr_instret_gc       = 12'hc02;
   localparam csr_addr_t addr_mstatus_gc       = 12'h300;
   localparam csr_addr_t addr_misa_gc          = 12'h301;
   localparam csr_addr_t addr_mie_gc           = 12'h304;
   localparam csr_addr_t addr_mtvec_gc         = 12'h305;
   localparam csr_addr_t addr_mcounteren_gc    = 12'h306;
   localparam csr_addr_t addr_mcountinhibit_gc = 12'h320;
   localparam csr_addr_t addr_mscratch_gc      = 12'h340;
   localparam csr_addr_t addr_mepc_gc          = 12'h341;
   localparam csr_addr_t addr_mcause_gc        = 12'h342;
   localparam csr_addr_t addr_mtval_gc         = 12'h343;
   localparam csr_addr_t addr_mip_gc           = 12'h344;
   localparam csr_addr_t addr_mcycle_gc        = 12'hb00;
   localparam csr_addr_t addr_minstret_gc      = 12'hb02;
   localparam csr_addr_t addr_mhartid_gc       = 12'hf14;

   // MXL of 2 with the I, M and U extension bits
   localparam logic [xlen_gp-1:0] misa_val_gc = {2'b10, 36'b0, 26'h0101100};

   localparam logic [3:0] ecode_illegal_gc    = 4'd2;
   localparam logic [3:0] ecode_breakpoint_gc = 4'd3;
   localparam logic [3:0] ecode_ecall_u_gc    = 4'd8;
   localparam logic [3:0] ecode_ecall_m_gc    = 4'd11;

   // Also the bit positions in mie and mip
   localparam logic [3:0] icode_software_gc = 4'd3;
   localparam logic [3:0] icode_timer_gc    = 4'd7;
   localparam logic [3:0] icode_external_gc = 4'd11;

   typedef struct packed {
      csr_op_e            op;
      csr_addr_t          addr;
      logic [xlen_gp-1:0] data;
   } csr_cmd_s;

   typedef struct packed {
      logic               instret;
      logic               exc_v;
      logic               illegal_ext;
      logic [xlen_gp-1:0] pc;
      logic [xlen_gp-1:0] npc;
      logic [31:0]        instr;
   } retire_s;

   typedef struct packed {
      logic [63:13] wpri_63_13;
      priv_e        mpp;
      logic [10:8]  wpri_10_8;
      logic         mpie;
      logic [6:4]   wpri_6_4;
      logic         mie;
      logic [2:0]   wpri_2_0;
   } mstatus_s;

   typedef union packed {
      logic [xlen_gp-1:0] raw;
      mstatus_s           f;
   } mstatus_u;

   typedef struct packed {
      logic msip;
      logic mtip;
      logic meip;
   } irq_s;

   typedef struct packed {
      logic               v;
      csr_addr_t          addr;
      logic [xlen_gp-1:0] data;
   } csr_wr_s;

   typedef struct packed {
      logic               take;
      logic               is_mret;
      logic               interrupt;
      logic [3:0]         ecode;
      logic [xlen_gp-1:0] epc;
      logic [xlen_gp-1:0] tval;
      priv_e              prev_priv;
   } trap_upd_s;

   typedef struct packed {
      logic               v;
      logic               exception;
      logic               interrupt;
      logic               eret;
      logic               instret;
      logic [xlen_gp-1:0] npc;
      priv_e              priv_n;
   } commit_s;

endpackage

// ==== logic/csr_access.sv ====
module csr_access
   (input  logic                          clk_i
    , input  csr_pkg::csr_cmd_s            cmd_i
    , input  logic                         cmd_v_i
    , input  csr_pkg::priv_e               priv_i
    , input  logic [csr_pkg::xlen_gp-1:0]  rdata_i
    , input  logic                         rvalid_i
    , input  logic [csr_pkg::xlen_gp-1:0]  mcounteren_i
    , output logic [csr_pkg::xlen_gp-1:0]  csr_data_o
    , output csr_pkg::csr_wr_s             wr_o
    , output logic                         illegal_o
    );

   import csr_pkg::*;

   logic                is_csr_op;
   logic                is_imm;
   logic [xlen_gp-1:0]  src;
   logic [xlen_gp-1:0]  wdata;
   logic                priv_fault;
   logic                counter_fault;
   logic                read_only;

   assign is_csr_op = cmd_v_i & (cmd_i.op inside {e_rw, e_rs, e_rc, e_rwi, e_rsi, e_rci});
   assign is_imm    = cmd_i.op inside {e_rwi, e_rsi, e_rci};

   // Immediate forms carry a 5-bit zimm in the low data bits
   assign src = is_imm ? xlen_gp'(cmd_i.data[4:0]) : cmd_i.data;

   always_comb
   begin
      unique case (cmd_i.op)
         e_rw, e_rwi: wdata = src;
         e_rs, e_rsi: wdata = rdata_i | src;
         e_rc, e_rci: wdata = rdata_i & ~src;
         default:     wdata = rdata_i;
      endcase
   end

   // Address bits 9:8 give the lowest privilege allowed
   assign priv_fault = cmd_i.addr[9:8] > priv_i;

   // User counter reads gated by mcounteren CY and IR
   assign counter_fault = (priv_i == e_priv_u)
                          & (((cmd_i.addr == addr_cycle_gc) & ~mcounteren_i[0])
                             | ((cmd_i.addr == addr_instret_gc) & ~mcounteren_i[2]));

   assign read_only = cmd_i.addr inside {addr_misa_gc, addr_mhartid_gc};

   assign illegal_o  = is_csr_op & (priv_fault | counter_fault | ~rvalid_i);
   assign csr_data_o = rdata_i;

   assign wr_o.v    = is_csr_op & ~illegal_o & ~read_only;
   assign wr_o.addr = cmd_i.addr;
   assign wr_o.data = wdata;

   // Privilege compare above assumes only U and M
   a_priv_legal : assert property (@(posedge clk_i)
      cmd_v_i |-> priv_i inside {e_priv_u, e_priv_m});

endmodule

// ==== logic/csr_regfile.sv ====
module csr_regfile
   #(parameter logic [csr_pkg::xlen_gp-1:0] hart_id_p = '0)
   (input  logic                          clk_i
    , input  logic                         rst_n_i
    , input  csr_pkg::csr_addr_t           raddr_i
    , input  csr_pkg::csr_wr_s             wr_i
    , input  csr_pkg::trap_upd_s           upd_i
    , input  csr_pkg::irq_s                irq_i
    , output logic [csr_pkg::xlen_gp-1:0]  rdata_o
    , output logic                         rvalid_o
    , output csr_pkg::mstatus_u            mstatus_o
    , output csr_pkg::irq_s                mie_o
    , output csr_pkg::irq_s                mip_o
    , output logic [csr_pkg::xlen_gp-1:0]  mtvec_o
    , output logic [csr_pkg::xlen_gp-1:0]  mepc_o
    , output logic [csr_pkg::xlen_gp-1:0]  mcounteren_o
    );

   import csr_pkg::*;

   mstatus_u            mstatus_r;
   mstatus_u            wr_view;
   mstatus_u            mstatus_wr;
   irq_s                mie_r;
   irq_s                mip_r;
   logic [xlen_gp-1:0]  mtvec_r;
   logic [xlen_gp-1:0]  mcounteren_r;
   logic [xlen_gp-1:0]  mscratch_r;
   logic [xlen_gp-1:0]  mepc_r;
   logic [xlen_gp-1:0]  mcause_r;
   logic [xlen_gp-1:0]  mtval_r;

   function automatic logic [xlen_gp-1:0] irq_word(irq_s bits);
      logic [xlen_gp-1:0] w;
      w = '0;
      w[icode_software_gc] = bits.msip;
      w[icode_timer_gc]    = bits.mtip;
      w[icode_external_gc] = bits.meip;
      return w;
   endfunction

   function automatic irq_s irq_bits(logic [xlen_gp-1:0] w);
      irq_s bits;
      bits.msip = w[icode_software_gc];
      bits.mtip = w[icode_timer_gc];
      bits.meip = w[icode_external_gc];
      return bits;
   endfunction

   // Only mie, mpie and mpp are writable
   assign wr_view.raw = wr_i.data;

   always_comb
   begin
      mstatus_wr.raw    = '0;
      mstatus_wr.f.mie  = wr_view.f.mie;
      mstatus_wr.f.mpie = wr_view.f.mpie;
      mstatus_wr.f.mpp  = (wr_view.f.mpp == e_priv_m) ? e_priv_m : e_priv_u;
   end

   always_comb
   begin
      rvalid_o = 1'b1;
      case (raddr_i)
         addr_mstatus_gc:    rdata_o = mstatus_r.raw;
         addr_misa_gc:       rdata_o = misa_val_gc;
         addr_mie_gc:        rdata_o = irq_word(mie_r);
         addr_mtvec_gc:      rdata_o = mtvec_r;
         addr_mcounteren_gc: rdata_o = mcounteren_r;
         addr_mscratch_gc:   rdata_o = mscratch_r;
         addr_mepc_gc:       rdata_o = mepc_r;
         addr_mcause_gc:     rdata_o = mcause_r;
         addr_mtval_gc:      rdata_o = mtval_r;
         addr_mip_gc:        rdata_o = irq_word(mip_r);
         addr_mhartid_gc:    rdata_o = hart_id_p;
         default:
         begin
            rdata_o  = '0;
            rvalid_o = 1'b0;
         end
      endcase
   end

   always_ff @(posedge clk_i)
   begin
      if (!rst_n_i)
      begin
         mstatus_r.raw <= '0;
         mie_r         <= '0;
         mip_r         <= '0;
         mtvec_r       <= '0;
         mcounteren_r  <= '0;
         mscratch_r    <= '0;
         mepc_r        <= '0;
         mcause_r      <= '0;
         mtval_r       <= '0;
      end
      else
      begin
         mip_r <= irq_i;

         if (wr_i.v)
         begin
            case (wr_i.addr)
               addr_mstatus_gc:    mstatus_r <= mstatus_wr;
               addr_mie_gc:        mie_r <= irq_bits(wr_i.data);
               addr_mtvec_gc:      mtvec_r <= wr_i.data;
               addr_mcounteren_gc: mcounteren_r <= wr_i.data;
               addr_mscratch_gc:   mscratch_r <= wr_i.data;
               addr_mepc_gc:       mepc_r <= wr_i.data;
               addr_mcause_gc:     mcause_r <= wr_i.data;
               addr_mtval_gc:      mtval_r <= wr_i.data;
               default:            ;
            endcase
         end

         // Trap and return updates land after the write so they win
         if (upd_i.take)
         begin
            mstatus_r.f.mie  <= 1'b0;
            mstatus_r.f.mpie <= mstatus_r.f.mie;
            mstatus_r.f.mpp  <= upd_i.prev_priv;
            mepc_r           <= upd_i.epc;
            mcause_r         <= {upd_i.interrupt, {(xlen_gp-5){1'b0}}, upd_i.ecode};
            mtval_r          <= upd_i.tval;
         end
         else if (upd_i.is_mret)
         begin
            mstatus_r.f.mie  <= mstatus_r.f.mpie;
            mstatus_r.f.mpie <= 1'b1;
            mstatus_r.f.mpp  <= e_priv_u;
         end
      end
   end

   assign mstatus_o    = mstatus_r;
   assign mie_o        = mie_r;
   assign mip_o        = mip_r;
   assign mtvec_o      = mtvec_r;
   assign mepc_o       = mepc_r;
   assign mcounteren_o = mcounteren_r;

   a_mpp_legal : assert property (@(posedge clk_i) disable iff (!rst_n_i)
      mstatus_r.f.mpp inside {e_priv_u, e_priv_m});

endmodule

// ==== logic/csr_counters.sv ====
module csr_counters
   (input  logic                          clk_i
    , input  logic                         rst_n_i
    , input  csr_pkg::csr_addr_t           raddr_i
    , input  csr_pkg::csr_wr_s             wr_i
    , input  logic                         instret_i
    , output logic [csr_pkg::xlen_gp-1:0]  rdata_o
    , output logic                         rvalid_o
    );

   import csr_pkg::*;

   logic [xlen_gp-1:0]  mcycle_r;
   logic [xlen_gp-1:0]  minstret_r;
   logic                inhibit_cy_r;
   logic                inhibit_ir_r;
   logic                wr_cycle;
   logic                wr_instret;
   logic                wr_inhibit;

   // User aliases write through to the machine counters
   assign wr_cycle   = wr_i.v & (wr_i.addr inside {addr_mcycle_gc, addr_cycle_gc});
   assign wr_instret = wr_i.v & (wr_i.addr inside {addr_minstret_gc, addr_instret_gc});
   assign wr_inhibit = wr_i.v & (wr_i.addr == addr_mcountinhibit_gc);

   always_ff @(posedge clk_i)
   begin
      if (!rst_n_i)
      begin
         mcycle_r     <= '0;
         minstret_r   <= '0;
         inhibit_cy_r <= 1'b0;
         inhibit_ir_r <= 1'b0;
      end
      else
      begin
         if (wr_cycle)
            mcycle_r <= wr_i.data;
         else if (!inhibit_cy_r)
            mcycle_r <= mcycle_r + xlen_gp'(1);

         if (wr_instret)
            minstret_r <= wr_i.data;
         else if (instret_i && !inhibit_ir_r)
            minstret_r <= minstret_r + xlen_gp'(1);

         if (wr_inhibit)
         begin
            inhibit_cy_r <= wr_i.data[0];
            inhibit_ir_r <= wr_i.data[2];
         end
      end
   end

   always_comb
   begin
      rvalid_o = 1'b1;
      case (raddr_i)
         addr_mcycle_gc, addr_cycle_gc:     rdata_o = mcycle_r;
         addr_minstret_gc, addr_instret_gc: rdata_o = minstret_r;
         addr_mcountinhibit_gc:
            rdata_o = {{(xlen_gp-3){1'b0}}, inhibit_ir_r, 1'b0, inhibit_cy_r};
         default:
         begin
            rdata_o  = '0;
            rvalid_o = 1'b0;
         end
      endcase
   end

endmodule

// ==== logic/trap_ctrl.sv ====
module trap_ctrl
   #(parameter logic [csr_pkg::xlen_gp-1:0] boot_pc_p = '0)
   (input  logic                          clk_i
    , input  logic                         rst_n_i
    , input  csr_pkg::csr_cmd_s            cmd_i
    , input  logic                         cmd_v_i
    , input  csr_pkg::retire_s             retire_i
    , input  logic                         illegal_i
    , input  logic                         interrupt_v_i
    , input  csr_pkg::mstatus_u            mstatus_i
    , input  csr_pkg::irq_s                mie_i
    , input  csr_pkg::irq_s                mip_i
    , input  logic [csr_pkg::xlen_gp-1:0]  mtvec_i
    , input  logic [csr_pkg::xlen_gp-1:0]  mepc_i
    , output csr_pkg::priv_e               priv_o
    , output csr_pkg::trap_upd_s           upd_o
    , output logic                         interrupt_ready_o
    , output csr_pkg::commit_s             commit_o
    );

   import csr_pkg::*;

   priv_e               priv_r;
   priv_e               priv_n;
   logic [xlen_gp-1:0]  apc_r;
   logic [xlen_gp-1:0]  apc_n;
   logic                is_m_mode;
   logic                mgie;
   irq_s                irq_pend;
   logic                mret_v;
   logic                illegal_v;
   logic                ebreak_v;
   logic                ecall_v;
   logic [3:0]          exc_code;
   logic [3:0]          irq_code;
   logic                take_irq;
   logic                take_exc;
   logic                take_ret;

   assign is_m_mode = priv_r == e_priv_m;

   // In U mode machine interrupts are enabled regardless of mstatus.mie
   assign mgie = mstatus_i.f.mie | ~is_m_mode;

   assign irq_pend.msip = mie_i.msip & mip_i.msip & mgie;
   assign irq_pend.mtip = mie_i.mtip & mip_i.mtip & mgie;
   assign irq_pend.meip = mie_i.meip & mip_i.meip & mgie;

   assign mret_v    = cmd_v_i & (cmd_i.op == e_mret);
   assign illegal_v = illegal_i | retire_i.illegal_ext | (mret_v & ~is_m_mode);
   assign ebreak_v  = cmd_v_i & (cmd_i.op == e_ebreak);
   assign ecall_v   = cmd_v_i & (cmd_i.op == e_ecall);

   // Lowest code first
   always_comb
   begin
      if (illegal_v)
         exc_code = ecode_illegal_gc;
      else if (ebreak_v)
         exc_code = ecode_breakpoint_gc;
      else if (is_m_mode)
         exc_code = ecode_ecall_m_gc;
      else
         exc_code = ecode_ecall_u_gc;

      if (irq_pend.msip)
         irq_code = icode_software_gc;
      else if (irq_pend.mtip)
         irq_code = icode_timer_gc;
      else
         irq_code = icode_external_gc;
   end

   assign interrupt_ready_o = |irq_pend;

   assign take_irq = interrupt_v_i & interrupt_ready_o;
   assign take_exc = ~take_irq & retire_i.exc_v & (illegal_v | ebreak_v | ecall_v);
   assign take_ret = ~take_irq & ~take_exc & mret_v & is_m_mode;

   always_comb
   begin
      priv_n = priv_r;
      apc_n  = apc_r;
      if (take_ret)
      begin
         priv_n = mstatus_i.f.mpp;
         apc_n  = mepc_i;
      end
      else if (take_irq || take_exc)
      begin
         priv_n = e_priv_m;
         apc_n  = {mtvec_i[xlen_gp-1:2], 2'b00};
      end
      else if (retire_i.instret)
         apc_n = retire_i.npc;
   end

   always_ff @(posedge clk_i)
   begin
      if (!rst_n_i)
      begin
         priv_r <= e_priv_m;
         apc_r  <= boot_pc_p;
      end
      else
      begin
         priv_r <= priv_n;
         apc_r  <= apc_n;
      end
   end

   assign upd_o.take      = take_irq | take_exc;
   assign upd_o.is_mret   = take_ret;
   assign upd_o.interrupt = take_irq;
   assign upd_o.ecode     = take_irq ? irq_code : exc_code;
   // Interrupts resume at the next unretired instruction
   assign upd_o.epc       = take_irq ? apc_r : retire_i.pc;
   assign upd_o.tval      = (take_exc && exc_code == ecode_illegal_gc)
                            ? xlen_gp'(retire_i.instr) : '0;
   assign upd_o.prev_priv = priv_r;

   assign priv_o = priv_r;

   assign commit_o.v         = take_irq | take_exc | take_ret;
   assign commit_o.exception = take_exc;
   assign commit_o.interrupt = take_irq;
   assign commit_o.eret      = take_ret;
   assign commit_o.instret   = retire_i.instret;
   assign commit_o.npc       = apc_n;
   assign commit_o.priv_n    = priv_n;

   // Register bank clears mstatus.mie behind any trap
   a_trap_clears_mie : assert property (@(posedge clk_i) disable iff (!rst_n_i)
      (commit_o.exception || commit_o.interrupt) |=> !mstatus_i.f.mie);

endmodule

// ==== logic/csr_top.sv ====
module csr_top
   #(parameter logic [csr_pkg::xlen_gp-1:0] boot_pc_p = 64'h8000_0000
     , parameter logic [csr_pkg::xlen_gp-1:0] hart_id_p = '0
     )
   (input  logic                          clk_i
    , input  logic                         rst_n_i
    , input  csr_pkg::csr_cmd_s            cmd_i
    , input  logic                         cmd_v_i
    , input  csr_pkg::retire_s             retire_i
    , input  csr_pkg::irq_s                irq_i
    , input  logic                         interrupt_v_i
    , output logic [csr_pkg::xlen_gp-1:0]  csr_data_o
    , output logic                         interrupt_ready_o
    , output csr_pkg::commit_s             commit_o
    );

   import csr_pkg::*;

   logic [xlen_gp-1:0]  rf_rdata;
   logic                rf_rvalid;
   logic [xlen_gp-1:0]  cnt_rdata;
   logic                cnt_rvalid;
   logic [xlen_gp-1:0]  rdata;
   logic                rvalid;
   csr_wr_s             wr;
   logic                illegal;
   priv_e               priv;
   trap_upd_s           upd;
   mstatus_u            mstatus;
   irq_s                mie;
   irq_s                mip;
   logic [xlen_gp-1:0]  mtvec;
   logic [xlen_gp-1:0]  mepc;
   logic [xlen_gp-1:0]  mcounteren;

   // Each address is claimed by one unit at most
   assign rdata  = rf_rdata | cnt_rdata;
   assign rvalid = rf_rvalid | cnt_rvalid;

   csr_access access
      (.clk_i(clk_i)
       , .cmd_i(cmd_i)
       , .cmd_v_i(cmd_v_i)
       , .priv_i(priv)
       , .rdata_i(rdata)
       , .rvalid_i(rvalid)
       , .mcounteren_i(mcounteren)
       , .csr_data_o(csr_data_o)
       , .wr_o(wr)
       , .illegal_o(illegal)
       );

   csr_regfile #(.hart_id_p(hart_id_p)) regfile
      (.clk_i(clk_i)
       , .rst_n_i(rst_n_i)
       , .raddr_i(cmd_i.addr)
       , .wr_i(wr)
       , .upd_i(upd)
       , .irq_i(irq_i)
       , .rdata_o(rf_rdata)
       , .rvalid_o(rf_rvalid)
       , .mstatus_o(mstatus)
       , .mie_o(mie)
       , .mip_o(mip)
       , .mtvec_o(mtvec)
       , .mepc_o(mepc)
       , .mcounteren_o(mcounteren)
       );

   csr_counters counters
      (.clk_i(clk_i)
       , .rst_n_i(rst_n_i)
       , .raddr_i(cmd_i.addr)
       , .wr_i(wr)
       , .instret_i(retire_i.instret)
       , .rdata_o(cnt_rdata)
       , .rvalid_o(cnt_rvalid)
       );

   trap_ctrl #(.boot_pc_p(boot_pc_p)) trap
      (.clk_i(clk_i)
       , .rst_n_i(rst_n_i)
       , .cmd_i(cmd_i)
       , .cmd_v_i(cmd_v_i)
       , .retire_i(retire_i)
       , .illegal_i(illegal)
       , .interrupt_v_i(interrupt_v_i)
       , .mstatus_i(mstatus)
       , .mie_i(mie)
       , .mip_i(mip)
       , .mtvec_i(mtvec)
       , .mepc_i(mepc)
       , .priv_o(priv)
       , .upd_o(upd)
       , .interrupt_ready_o(interrupt_ready_o)
       , .commit_o(commit_o)
       );

endmodule

// ==== include/csr_tb_tasks.svh ====
`ifndef CSR_TB_TASKS_SVH
`define CSR_TB_TASKS_SVH

task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
   if (got !== exp)
   begin
      $display("mismatch %s: got %h expected %h", name, got, exp);
      errors++;
   end
endtask

function automatic logic [63:0] rand64();
   return {$random(seed), $random(seed)};
endfunction

// One command cycle, sampled at the falling edge
task automatic drive_cmd(input csr_op_e op, input csr_addr_t addr, input logic [63:0] data,
                         input logic [63:0] pc, input logic [31:0] instr);
   csr_cmd_s c;
   retire_s  r;
   c.op    = op;
   c.addr  = addr;
   c.data  = data;
   r       = '0;
   r.exc_v = 1'b1;
   r.pc    = pc;
   r.npc   = pc + 64'd4;
   r.instr = instr;
   @(posedge clk);
   cmd         <= c;
   cmd_v       <= 1'b1;
   retire      <= r;
   interrupt_v <= 1'b0;
   @(negedge clk);
endtask

task automatic idle_cycle(input logic instret, input logic [63:0] npc);
   retire_s r;
   r         = '0;
   r.instret = instret;
   r.npc     = npc;
   @(posedge clk);
   cmd_v       <= 1'b0;
   retire      <= r;
   interrupt_v <= 1'b0;
   @(negedge clk);
endtask

task automatic set_irq(input irq_s lines);
   @(posedge clk);
   cmd_v       <= 1'b0;
   retire      <= '0;
   interrupt_v <= 1'b0;
   irq         <= lines;
   @(negedge clk);
endtask

task automatic read_csr(input csr_addr_t addr, output logic [63:0] value);
   drive_cmd(e_rs, addr, '0, '0, 32'h0);
   value = csr_data;
endtask

task automatic wait_irq_ready();
   int n;
   n = 0;
   while (!irq_ready && n < 8)
   begin
      idle_cycle(1'b0, '0);
      n++;
   end
   if (!irq_ready)
   begin
      $display("interrupt_ready_o did not rise within 8 cycles");
      errors++;
   end
endtask

task automatic report_test(input string name, input int errs_at_start);
   if (errors == errs_at_start)
   begin
      $display("%s: ok", name);
      passed++;
   end
   else
   begin
      $display("%s: %0d errors", name, errors - errs_at_start);
      failed++;
   end
endtask

task automatic test_access();
   csr_op_e     ops[5] = '{e_rs, e_rc, e_rwi, e_rsi, e_rci};
   int          e0;
   logic [63:0] d;
   logic [63:0] src;
   logic [63:0] exp;
   logic [63:0] rd;
   e0 = errors;
   d  = rand64();
   drive_cmd(e_rw, addr_mscratch_gc, d, '0, 32'h0);
   exp = d;
   for (int i = 0; i < 5; i++)
   begin
      d = rand64();
      drive_cmd(ops[i], addr_mscratch_gc, d, '0, 32'h0);
      check("csr_data_o", csr_data, exp);
      // Immediate forms use only a zero-extended zimm
      src = (i >= 2) ? {59'b0, d[4:0]} : d;
      case (ops[i])
         e_rs, e_rsi: exp = exp | src;
         e_rc, e_rci: exp = exp & ~src;
         default:     exp = src;
      endcase
   end
   read_csr(addr_mscratch_gc, rd);
   check("mscratch", rd, exp);
   // MXL 2 with I, M and U
   read_csr(addr_misa_gc, rd);
   check("misa", rd, 64'h8000_0000_0010_1100);
   read_csr(addr_mhartid_gc, rd);
   check("mhartid", rd, 64'd5);
   drive_cmd(e_rs, 12'h7c0, '0, rand64(), 32'h7c002573);
   check("commit_o.exception", 64'(commit.exception), 64'd1);
   read_csr(addr_mcause_gc, rd);
   check("mcause", rd, 64'd2);
   report_test("access operations", e0);
endtask

task automatic test_counters();
   int          e0;
   logic [63:0] w;
   logic [63:0] frozen;
   logic [63:0] base;
   logic [63:0] rd;
   e0 = errors;
   w  = rand64();
   drive_cmd(e_rw, addr_mcycle_gc, w, '0, 32'h0);
   repeat (4) idle_cycle(1'b0, '0);
   // Read five cycles after the write
   read_csr(addr_mcycle_gc, rd);
   check("mcycle", rd, w + 64'd4);
   drive_cmd(e_rw, addr_mcountinhibit_gc, 64'd1, '0, 32'h0);
   read_csr(addr_mcycle_gc, frozen);
   repeat (3) idle_cycle(1'b0, '0);
   read_csr(addr_mcycle_gc, rd);
   check("mcycle inhibited", rd, frozen);
   drive_cmd(e_rw, addr_mcountinhibit_gc, 64'd0, '0, 32'h0);
   read_csr(addr_minstret_gc, base);
   repeat (3) idle_cycle(1'b1, rand64());
   read_csr(addr_minstret_gc, rd);
   check("minstret", rd, base + 64'd3);
   report_test("counters", e0);
endtask

task automatic test_trap_return();
   int          e0;
   logic [63:0] tv;
   logic [63:0] pc;
   logic [63:0] rd;
   e0 = errors;
   tv = rand64();
   drive_cmd(e_rw, addr_mtvec_gc, tv, '0, 32'h0);
   pc = rand64();
   drive_cmd(e_ecall, 12'h0, '0, pc, 32'h0000_0073);
   check("commit_o.v", 64'(commit.v), 64'd1);
   check("commit_o.exception", 64'(commit.exception), 64'd1);
   check("commit_o.npc", commit.npc, {tv[63:2], 2'b00});
   read_csr(addr_mcause_gc, rd);
   check("mcause", rd, 64'd11);
   read_csr(addr_mepc_gc, rd);
   check("mepc", rd, pc);
   read_csr(addr_mstatus_gc, rd);
   check("mstatus.mpp", 64'(rd[12:11]), 64'd3);
   drive_cmd(e_mret, 12'h0, '0, '0, 32'h3020_0073);
   check("commit_o.eret", 64'(commit.eret), 64'd1);
   check("commit_o.npc", commit.npc, pc);
   report_test("trap and return", e0);
endtask

task automatic test_user_priv();
   int          e0;
   logic [31:0] instr;
   logic [63:0] rd;
   e0 = errors;
   drive_cmd(e_rw, addr_mstatus_gc, '0, '0, 32'h0);
   drive_cmd(e_mret, 12'h0, '0, '0, 32'h3020_0073);
   check("commit_o.priv_n", 64'(commit.priv_n), 64'd0);
   instr = $random(seed);
   drive_cmd(e_rs, addr_mstatus_gc, '0, rand64(), instr);
   check("commit_o.exception", 64'(commit.exception), 64'd1);
   read_csr(addr_mcause_gc, rd);
   check("mcause", rd, 64'd2);
   read_csr(addr_mtval_gc, rd);
   check("mtval", rd, {32'b0, instr});
   // The trap left mpp at U, so mret drops back to U
   drive_cmd(e_mret, 12'h0, '0, '0, 32'h3020_0073);
   drive_cmd(e_rs, addr_cycle_gc, '0, rand64(), 32'hc000_2573);
   check("commit_o.exception", 64'(commit.exception), 64'd1);
   read_csr(addr_mcause_gc, rd);
   check("mcause", rd, 64'd2);
   drive_cmd(e_rw, addr_mcounteren_gc, 64'd1, '0, 32'h0);
   drive_cmd(e_mret, 12'h0, '0, '0, 32'h3020_0073);
   drive_cmd(e_rs, addr_cycle_gc, '0, rand64(), 32'hc000_2573);
   check("commit_o.exception", 64'(commit.exception), 64'd0);
   drive_cmd(e_ecall, 12'h0, '0, rand64(), 32'h0000_0073);
   check("commit_o.exception", 64'(commit.exception), 64'd1);
   read_csr(addr_mcause_gc, rd);
   check("mcause", rd, 64'd8);
   report_test("user privilege", e0);
endtask

task automatic test_interrupts();
   int          e0;
   irq_s        lines;
   logic [63:0] npc;
   logic [63:0] rd;
   e0 = errors;
   drive_cmd(e_rw, addr_mie_gc, 64'h888, '0, 32'h0);
   // mpp M and global enable set
   drive_cmd(e_rw, addr_mstatus_gc, 64'h1808, '0, 32'h0);
   npc = rand64();
   idle_cycle(1'b1, npc);
   check("commit_o.instret", 64'(commit.instret), 64'd1);
   check("commit_o.npc", commit.npc, npc);
   lines.msip = 1'b1;
   lines.mtip = 1'b1;
   lines.meip = 1'b0;
   set_irq(lines);
   wait_irq_ready();
   @(posedge clk);
   interrupt_v <= 1'b1;
   @(negedge clk);
   check("commit_o.interrupt", 64'(commit.interrupt), 64'd1);
   read_csr(addr_mcause_gc, rd);
   check("mcause", rd, 64'h8000_0000_0000_0003);
   check("interrupt_ready_o", 64'(irq_ready), 64'd0);
   read_csr(addr_mepc_gc, rd);
   check("mepc", rd, npc);
   read_csr(addr_mstatus_gc, rd);
   check("mstatus.mie", 64'(rd[3]), 64'd0);
   check("interrupt_ready_o", 64'(irq_ready), 64'd0);
   set_irq('0);
   report_test("interrupts", e0);
endtask

`endif

// ==== tb/csr_tb.sv ====
module csr_tb;

   import csr_pkg::*;

   // About thirty times the length of the whole test sequence
   localparam int max_cycles_gc = 2000;

   logic                clk;
   logic                rst_n;
   csr_cmd_s            cmd;
   logic                cmd_v;
   retire_s             retire;
   irq_s                irq;
   logic                interrupt_v;
   logic [xlen_gp-1:0]  csr_data;
   logic                irq_ready;
   commit_s             commit;
   int                  seed;
   int                  errors;
   int                  passed;
   int                  failed;
   int                  cycles = 0;

   csr_top #(.boot_pc_p(64'h8000_0000), .hart_id_p(64'd5)) uut
      (.clk_i(clk)
       , .rst_n_i(rst_n)
       , .cmd_i(cmd)
       , .cmd_v_i(cmd_v)
       , .retire_i(retire)
       , .irq_i(irq)
       , .interrupt_v_i(interrupt_v)
       , .csr_data_o(csr_data)
       , .interrupt_ready_o(irq_ready)
       , .commit_o(commit)
       );

   `include "csr_tb_tasks.svh"

   initial
   begin
      clk = 1'b0;
      forever
         #2 clk = ~clk;
   end

   always @(posedge clk)
   begin
      cycles <= cycles + 1;
      if (cycles >= max_cycles_gc)
      begin
         $display("timeout: the tests did not finish within %0d cycles", max_cycles_gc);
         $display("TESTS FAILED");
         $finish;
      end
   end

   initial
   begin
      seed        = 32'h721b1336;
      errors      = 0;
      passed      = 0;
      failed      = 0;
      rst_n       <= 1'b0;
      cmd         <= '0;
      cmd_v       <= 1'b0;
      retire      <= '0;
      irq         <= '0;
      interrupt_v <= 1'b0;

      // Reset held low over four rising edges
      repeat (4) @(posedge clk);
      rst_n <= 1'b1;

      test_access();
      test_counters();
      test_trap_return();
      test_user_priv();
      test_interrupts();
      idle_cycle(1'b0, '0);

      $display("summary: %0d tests ok, %0d tests with errors", passed, failed);
      if (errors == 0)
      begin
         $display("TESTS PASSED");
      end
      else
      begin
         $display("TESTS FAILED");
      end
      $finish;
   end

endmodule

// ==== filelist.f ====
+incdir+include
logic/csr_pkg.sv
logic/csr_access.sv
logic/csr_regfile.sv
logic/csr_counters.sv
logic/trap_ctrl.sv
logic/csr_top.sv
tb/csr_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert -f filelist.f --top-module csr_tb -o csr_sim
./obj_dir/csr_sim > sim.log 2>&1
cat sim.log

if grep -q "TESTS FAILED" sim.log; then
   exit 1
fi
exit 0
